// File: logic/spi_pkg.sv
package spi_pkg;

  //////////////////////////////
  // Bus timing
  localparam int SCLK_RATIO    = 8;   // System clocks per SCLK period, even
  localparam int PHASE_BITS    = $clog2(SCLK_RATIO);
  localparam int SS_PERIODS    = 4;   // SCLK periods per chip-select setup/hold state
  localparam int RX_PIPE_DEPTH = 3;   // cipo sample point after SCLK rise, < SCLK_RATIO/2

  //////////////////////////////
  // Sizes
  localparam int FIFO_DEPTH    = 16;  // Power of two, pointers wrap freely
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int LEN_BITS      = 4;
  localparam int WAIT_BITS     = 2;
  localparam int TIMER_MAX     = 8 * (2 ** LEN_BITS - 1);  // Longest phase in bits
  localparam int TIMER_BITS    = $clog2(TIMER_MAX + 1);

  typedef logic [7:0]            byte_t;
  typedef logic [LEN_BITS-1:0]   len_t;
  typedef logic [WAIT_BITS-1:0]  wait_t;
  typedef logic [TIMER_BITS-1:0] timer_t;     // SCLK periods in current state
  typedef logic [PHASE_BITS-1:0] phase_cnt_t; // Position within one SCLK period

  // Bus phases in the order they run
  typedef enum logic [2:0] {
    ST_IDLE, ST_START_D, ST_START_S, ST_TX,
    ST_WAIT, ST_RX, ST_STOP_S, ST_STOP_D
  } bus_state_t;

  // Transfer request
  typedef struct packed {
    logic  go;        // One-cycle strobe
    len_t  tx_len;    // Bytes out, at least one
    len_t  rx_len;    // Bytes in, zero skips RX
    wait_t wait_cyc;  // Idle SCLK periods between TX and RX
  } spi_cmd_t;

  // Decoded SCLK phase
  typedef struct packed {
    logic sck_level;  // SCLK level when running
    logic fall_ce;    // State and timer update, SCLK falls here
    logic sample_ce;  // cipo sample point
  } spi_phase_t;

endpackage

// File: logic/spi_sync_fifo.sv
`timescale 1ns/1ps

module spi_sync_fifo (
  input  logic           i_ext_spi_clk_x,
  input  logic           i_srst,
  input  logic           push_i,
  input  spi_pkg::byte_t push_data_i,
  input  logic           pop_i,
  output spi_pkg::byte_t head_o,
  output logic           empty_o,
  output logic           full_o
);

  spi_pkg::byte_t                    mem [spi_pkg::FIFO_DEPTH];
  logic [spi_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
  logic [spi_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
  logic [spi_pkg::FIFO_PTR_BITS:0]   count;   // Occupancy, one bit wider than pointers
  logic                              do_push;
  logic                              do_pop;

  assign do_push = push_i && !full_o;   // Push into full dropped
  assign do_pop  = pop_i && !empty_o;   // Pop from empty dropped

  // Storage
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  // Pointers and occupancy
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  assign head_o  = mem[rd_ptr];  // First word falls through
  assign empty_o = (count == '0);
  assign full_o  = (count == (spi_pkg::FIFO_PTR_BITS + 1)'(spi_pkg::FIFO_DEPTH));

endmodule

// File: logic/spi_phase_gen.sv
`timescale 1ns/1ps

module spi_phase_gen (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  output spi_pkg::spi_phase_t phase_o
);

  spi_pkg::phase_cnt_t cnt_q;

  // Free running, 0 .. SCLK_RATIO-1
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      cnt_q <= '0;
    else if (cnt_q == spi_pkg::phase_cnt_t'(spi_pkg::SCLK_RATIO - 1))
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 1'b1;
  end

  // High half first, rising edge at counter zero
  always_comb begin
    phase_o.sck_level = (cnt_q < spi_pkg::phase_cnt_t'(spi_pkg::SCLK_RATIO / 2));
    // Last high cycle, registers loaded here change with SCLK falling
    phase_o.fall_ce   = (cnt_q == spi_pkg::phase_cnt_t'(spi_pkg::SCLK_RATIO / 2 - 1));
    // Late in the high half, after cipo has settled
    phase_o.sample_ce = (cnt_q == spi_pkg::phase_cnt_t'(spi_pkg::RX_PIPE_DEPTH));
  end

endmodule

// File: logic/spi_cmd_latch.sv
`timescale 1ns/1ps

module spi_cmd_latch (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  input  spi_pkg::spi_cmd_t cmd_i,
  input  logic              fsm_idle_i,
  output spi_pkg::spi_cmd_t cmd_o,
  output logic              go_hold_o,
  output logic              spi_idle_o
);

  typedef enum logic {
    LAT_WAIT,   // Idle, looking for go
    LAT_HOLD    // Stretching go over one SCLK period
  } lat_state_t;

  lat_state_t          state_q;
  spi_pkg::phase_cnt_t hold_cnt;
  spi_pkg::len_t       tx_len_q;
  spi_pkg::len_t       rx_len_q;
  spi_pkg::wait_t      wait_q;
  logic                accept;

  assign accept = cmd_i.go && spi_idle_o;  // go while busy is dropped

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q  <= LAT_WAIT;
      hold_cnt <= '0;
      tx_len_q <= '0;
      rx_len_q <= '0;
      wait_q   <= '0;
    end else begin
      case (state_q)
        LAT_HOLD: begin
          hold_cnt <= hold_cnt + 1'b1;
          if (hold_cnt == spi_pkg::phase_cnt_t'(spi_pkg::SCLK_RATIO - 1))
            state_q <= LAT_WAIT;   // Hold spans exactly one fall_ce
        end
        default: begin
          hold_cnt <= '0;
          if (accept) begin
            state_q  <= LAT_HOLD;
            tx_len_q <= cmd_i.tx_len;  // Kept until the next accepted go
            rx_len_q <= cmd_i.rx_len;
            wait_q   <= cmd_i.wait_cyc;
          end
        end
      endcase
    end
  end

  assign go_hold_o  = (state_q == LAT_HOLD);
  assign spi_idle_o = fsm_idle_i && (state_q == LAT_WAIT);

  // Latched command, go field carries the stretched level
  always_comb begin
    cmd_o.go       = go_hold_o;
    cmd_o.tx_len   = tx_len_q;
    cmd_o.rx_len   = rx_len_q;
    cmd_o.wait_cyc = wait_q;
  end

endmodule

// File: logic/spi_bus_fsm.sv
`timescale 1ns/1ps

module spi_bus_fsm (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  spi_pkg::spi_phase_t phase_i,
  input  spi_pkg::spi_cmd_t   cmd_i,
  input  logic                go_hold_i,
  input  spi_pkg::byte_t      tx_head_i,
  input  logic                tx_empty_i,
  output logic                tx_pop_o,
  output spi_pkg::bus_state_t state_o,
  output spi_pkg::timer_t     timer_o,
  output logic                fsm_idle_o,
  output logic                sck_o,
  output logic                csn_o,
  output logic                copi_o
);

  spi_pkg::bus_state_t state_q;
  spi_pkg::bus_state_t state_d;
  spi_pkg::timer_t     timer_q;
  spi_pkg::timer_t     ss_last;    // Last period of a setup/hold state
  spi_pkg::timer_t     tx_last;
  spi_pkg::timer_t     rx_last;
  spi_pkg::timer_t     wait_last;
  logic                sck_run;

  //////////////////////////////
  // Phase lengths
  always_comb begin
    ss_last   = spi_pkg::timer_t'(spi_pkg::SS_PERIODS - 1);
    tx_last   = spi_pkg::timer_t'({cmd_i.tx_len, 3'b000} - 1);   // 8 bits per byte
    rx_last   = spi_pkg::timer_t'({cmd_i.rx_len, 3'b000} - 1);
    wait_last = spi_pkg::timer_t'(cmd_i.wait_cyc) - spi_pkg::timer_t'(1);
  end

  //////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;  // Stay by default
    case (state_q)
      spi_pkg::ST_IDLE:
        if (go_hold_i)
          state_d = spi_pkg::ST_START_D;
      spi_pkg::ST_START_D:
        if (timer_q == ss_last)
          state_d = spi_pkg::ST_START_S;
      spi_pkg::ST_START_S:
        if (timer_q == ss_last)
          state_d = spi_pkg::ST_TX;
      spi_pkg::ST_TX: begin
        if (timer_q == tx_last) begin
          if (cmd_i.rx_len == '0)
            state_d = spi_pkg::ST_STOP_S;    // Write only
          else if (cmd_i.wait_cyc == '0)
            state_d = spi_pkg::ST_RX;        // No turnaround
          else
            state_d = spi_pkg::ST_WAIT;
        end
      end
      spi_pkg::ST_WAIT:
        if (timer_q == wait_last)
          state_d = spi_pkg::ST_RX;
      spi_pkg::ST_RX:
        if (timer_q == rx_last)
          state_d = spi_pkg::ST_STOP_S;
      spi_pkg::ST_STOP_S:
        if (timer_q == ss_last)
          state_d = spi_pkg::ST_STOP_D;
      default:            // ST_STOP_D
        if (timer_q == ss_last)
          state_d = spi_pkg::ST_IDLE;
    endcase
  end

  // State and bit timer, both move on the SCLK falling edge
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q <= spi_pkg::ST_IDLE;
      timer_q <= '0;
    end else if (phase_i.fall_ce) begin
      state_q <= state_d;
      if (state_d != state_q)
        timer_q <= '0;               // Fresh count per state
      else if (timer_q != spi_pkg::timer_t'(spi_pkg::TIMER_MAX))
        timer_q <= timer_q + 1'b1;   // Saturate
    end
  end

  //////////////////////////////
  // Bus outputs, Mode 0
  always_comb begin
    sck_run  = (state_q == spi_pkg::ST_TX) || (state_q == spi_pkg::ST_WAIT) ||
               (state_q == spi_pkg::ST_RX);
    sck_o    = sck_run && phase_i.sck_level;   // Parked low otherwise
    csn_o    = (state_q == spi_pkg::ST_IDLE) || (state_q == spi_pkg::ST_START_D) ||
               (state_q == spi_pkg::ST_STOP_D);
    // MSB first, ~bit index is 7 - (timer mod 8); empty FIFO sends zeros
    copi_o   = (state_q == spi_pkg::ST_TX) && !tx_empty_i && tx_head_i[~timer_q[2:0]];
    // Next byte to the head as the last bit of this one ends
    tx_pop_o = (state_q == spi_pkg::ST_TX) && phase_i.fall_ce &&
               (timer_q[2:0] == 3'd7) && !tx_empty_i;
  end

  assign fsm_idle_o = (state_q == spi_pkg::ST_IDLE);
  assign state_o    = state_q;
  assign timer_o    = timer_q;

endmodule

// File: logic/spi_rx_shifter.sv
`timescale 1ns/1ps

module spi_rx_shifter (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  spi_pkg::spi_phase_t phase_i,
  input  spi_pkg::bus_state_t state_i,
  input  spi_pkg::timer_t     timer_i,
  input  spi_pkg::spi_cmd_t   cmd_i,
  input  logic                cipo_i,
  input  logic                rx_full_i,
  output logic                rx_push_o,
  output spi_pkg::byte_t      rx_byte_o
);

  spi_pkg::bus_state_t state_dly [spi_pkg::RX_PIPE_DEPTH];
  spi_pkg::timer_t     timer_dly [spi_pkg::RX_PIPE_DEPTH];
  spi_pkg::bus_state_t state_tap;
  spi_pkg::timer_t     timer_tap;
  spi_pkg::byte_t      shift_q;
  logic                shift_en;
  logic                last_bit;

  // State and timer aligned to the sample point
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      for (int i = 0; i < spi_pkg::RX_PIPE_DEPTH; i++) begin
        state_dly[i] <= spi_pkg::ST_IDLE;
        timer_dly[i] <= '0;
      end
    end else begin
      state_dly[0] <= state_i;
      timer_dly[0] <= timer_i;
      for (int i = 1; i < spi_pkg::RX_PIPE_DEPTH; i++) begin
        state_dly[i] <= state_dly[i-1];
        timer_dly[i] <= timer_dly[i-1];
      end
    end
  end

  assign state_tap = state_dly[spi_pkg::RX_PIPE_DEPTH-1];
  assign timer_tap = timer_dly[spi_pkg::RX_PIPE_DEPTH-1];

  always_comb begin
    shift_en = phase_i.sample_ce && (state_tap == spi_pkg::ST_RX) &&
               (timer_tap < spi_pkg::timer_t'({cmd_i.rx_len, 3'b000}));
    last_bit = (timer_tap[2:0] == 3'd7);   // Eighth bit of a byte
  end

  // MSB first
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (shift_en)
      shift_q <= {shift_q[6:0], cipo_i};
  end

  // Push strobe lands one cycle after the eighth sample, dropped when full
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      rx_push_o <= 1'b0;
    else
      rx_push_o <= shift_en && last_bit && !rx_full_i;
  end

  assign rx_byte_o = shift_q;  // Stable for a whole SCLK period after push

endmodule

// File: logic/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  // Command and data side
  input  spi_pkg::spi_cmd_t cmd_i,
  input  spi_pkg::byte_t    tx_data_i,
  input  logic              tx_enqueue_i,
  output logic              tx_ready_o,
  output spi_pkg::byte_t    rx_data_o,
  output logic              rx_avail_o,
  input  logic              rx_dequeue_i,
  output logic              spi_idle_o,
  // SPI bus
  output logic              sck_o,
  output logic              csn_o,
  output logic              copi_o,
  input  logic              cipo_i
);

  spi_pkg::spi_phase_t phase;
  spi_pkg::spi_cmd_t   cmd_lat;
  spi_pkg::bus_state_t bus_state;
  spi_pkg::timer_t     bus_timer;
  spi_pkg::byte_t      tx_head;
  spi_pkg::byte_t      rx_byte;
  logic                go_hold;
  logic                fsm_idle;
  logic                tx_pop;
  logic                tx_empty;
  logic                tx_full;
  logic                rx_push;
  logic                rx_empty;
  logic                rx_full;

  spi_phase_gen u_phase (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .phase_o         (phase)
  );

  spi_cmd_latch u_cmd (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .cmd_i           (cmd_i),
    .fsm_idle_i      (fsm_idle),
    .cmd_o           (cmd_lat),
    .go_hold_o       (go_hold),
    .spi_idle_o      (spi_idle_o)
  );

  spi_bus_fsm u_fsm (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .phase_i         (phase),
    .cmd_i           (cmd_lat),
    .go_hold_i       (go_hold),
    .tx_head_i       (tx_head),
    .tx_empty_i      (tx_empty),
    .tx_pop_o        (tx_pop),
    .state_o         (bus_state),
    .timer_o         (bus_timer),
    .fsm_idle_o      (fsm_idle),
    .sck_o           (sck_o),
    .csn_o           (csn_o),
    .copi_o          (copi_o)
  );

  spi_rx_shifter u_rx (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .phase_i         (phase),
    .state_i         (bus_state),
    .timer_i         (bus_timer),
    .cmd_i           (cmd_lat),
    .cipo_i          (cipo_i),
    .rx_full_i       (rx_full),
    .rx_push_o       (rx_push),
    .rx_byte_o       (rx_byte)
  );

  //////////////////////////////
  // Byte queues
  spi_sync_fifo u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .push_i          (tx_enqueue_i),
    .push_data_i     (tx_data_i),
    .pop_i           (tx_pop),
    .head_o          (tx_head),
    .empty_o         (tx_empty),
    .full_o          (tx_full)
  );

  spi_sync_fifo u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .push_i          (rx_push),
    .push_data_i     (rx_byte),
    .pop_i           (rx_dequeue_i),
    .head_o          (rx_data_o),
    .empty_o         (rx_empty),
    .full_o          (rx_full)
  );

  assign tx_ready_o = !tx_full;   // Room for one more
  assign rx_avail_o = !rx_empty;  // Head valid

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #20 clk_o = ~clk_o;  // 40 ns period

endmodule

// File: test/spi_master_chk.sv
`timescale 1ns/1ps

module spi_master_chk (
  input  logic              i_ext_spi_clk_x,
  input  logic              i_srst,
  input  spi_pkg::spi_cmd_t cmd_i,
  input  logic              spi_idle_i,
  input  logic              sck_i,
  input  logic              csn_i,
  input  logic              copi_i
);

  logic seen_go;        // First go strobe has arrived
  int   rst_errs  = 0;
  int   sck_errs  = 0;
  int   csn_errs  = 0;
  int   copi_errs = 0;
  int   fail_cnt;       // Sum of all assertion failures

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst)
      seen_go <= 1'b0;
    else if (cmd_i.go)
      seen_go <= 1'b1;
  end

  //////////////////////////////
  // Bus protocol
  a_park_idle: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !seen_go |-> (csn_i && !sck_i && spi_idle_i))
    else begin
      rst_errs++;
      $error("Bus not parked idle before the first go");
    end

  a_sck_csn: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    csn_i |-> !sck_i)                  // Clock only inside a frame
    else begin
      sck_errs++;
      $error("sck high while csn deasserted");
    end

  a_csn_busy: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !csn_i |-> !spi_idle_i)
    else begin
      csn_errs++;
      $error("csn asserted while master reports idle");
    end

  // Mode 0 data set up before the rising edge and held through the high phase
  a_copi_stable: assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    sck_i |-> $stable(copi_i))
    else begin
      copi_errs++;
      $error("copi changed while sck high");
    end

  assign fail_cnt = rst_errs + sck_errs + csn_errs + copi_errs;

endmodule

bind spi_master_top spi_master_chk u_chk (
  .i_ext_spi_clk_x (i_ext_spi_clk_x),
  .i_srst          (i_srst),
  .cmd_i           (cmd_i),
  .spi_idle_i      (spi_idle_o),
  .sck_i           (sck_o),
  .csn_i           (csn_o),
  .copi_i          (copi_o)
);

// File: test/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;

  // Six transfers, worst case about 2100 cycles each, plus margin
  localparam int TIMEOUT_CYC = 20000;

  logic              clk;
  logic              srst;
  spi_pkg::spi_cmd_t cmd;
  spi_pkg::byte_t    tx_data;
  logic              tx_enqueue;
  logic              tx_ready;
  spi_pkg::byte_t    rx_data;
  logic              rx_avail;
  logic              rx_dequeue;
  logic              spi_idle;
  logic              sck;
  logic              csn;
  logic              copi;
  logic              cipo;

  int             seed      = 32'h10dfdbac;
  int             errors    = 0;
  int             cycles    = 0;
  int             chk_errs  = 0;
  int             rise_cnt  = 0;   // sck rises in the current transfer
  int             tx_bits   = 0;   // Leading rises that carry copi data
  int             skip_bits = 0;   // Rises before the first RX bit
  int             miso_idx;
  spi_pkg::byte_t mosi_shift;
  spi_pkg::byte_t exp_mosi [$];    // Enqueued, not yet on the bus
  spi_pkg::byte_t slave_mosi [$];  // Assembled by the slave
  spi_pkg::byte_t slave_miso [$];  // Slave reply bytes

  tb_clk_gen u_clk (.clk_o(clk));

  spi_master_top UUT (
    .i_ext_spi_clk_x (clk),
    .i_srst          (srst),
    .cmd_i           (cmd),
    .tx_data_i       (tx_data),
    .tx_enqueue_i    (tx_enqueue),
    .tx_ready_o      (tx_ready),
    .rx_data_o       (rx_data),
    .rx_avail_o      (rx_avail),
    .rx_dequeue_i    (rx_dequeue),
    .spi_idle_o      (spi_idle),
    .sck_o           (sck),
    .csn_o           (csn),
    .copi_o          (copi),
    .cipo_i          (cipo)
  );

  //////////////////////////////
  // SPI slave model, Mode 0
  always @(posedge sck) begin
    if (!csn) begin
      if (rise_cnt < tx_bits) begin
        mosi_shift = {mosi_shift[6:0], copi};   // MSB first
        if (rise_cnt % 8 == 7)
          slave_mosi.push_back(mosi_shift);
      end
      rise_cnt++;
    end
  end

  // Reply bit for the next rise, set up on the falling edge
  always @(negedge sck) begin
    if (!csn && rise_cnt >= skip_bits) begin
      miso_idx = rise_cnt - skip_bits;
      if (miso_idx / 8 < slave_miso.size())
        cipo <= slave_miso[miso_idx / 8][7 - miso_idx % 8];
      else
        cipo <= 1'b0;
    end
  end

  task automatic print_counts();
    chk_errs = UUT.u_chk.fail_cnt;
    $display("Errors: %0d testbench checks, %0d bus assertions", errors, chk_errs);
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, master never returned to idle", cycles);
      print_counts();
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic enqueue_bytes(input int n);
    spi_pkg::byte_t b;
    for (int i = 0; i < n; i++) begin
      b = spi_pkg::byte_t'($random(seed));
      exp_mosi.push_back(b);
      @(posedge clk);
      tx_data    <= b;
      tx_enqueue <= 1'b1;
    end
    @(posedge clk);
    tx_enqueue <= 1'b0;
  endtask

  task automatic run_transfer(input int txn, input int wcyc, input int rxn);
    int             exp_rises;
    spi_pkg::byte_t exp_b;
    slave_mosi.delete();
    slave_miso.delete();
    for (int i = 0; i < rxn; i++)
      slave_miso.push_back(spi_pkg::byte_t'($random(seed)));
    rise_cnt  = 0;
    tx_bits   = 8 * txn;
    skip_bits = 8 * txn + wcyc;
    exp_rises = 8 * (txn + rxn) + ((rxn != 0) ? wcyc : 0);  // WAIT only ahead of RX
    @(posedge clk);
    cmd.go       <= 1'b1;
    cmd.tx_len   <= spi_pkg::len_t'(txn);
    cmd.rx_len   <= spi_pkg::len_t'(rxn);
    cmd.wait_cyc <= spi_pkg::wait_t'(wcyc);
    @(posedge clk);
    cmd.go <= 1'b0;
    do @(negedge clk); while (!spi_idle);    // Busy, then idle again
    check_value("sck rise count", rise_cnt, exp_rises);
    check_value("slave byte count", slave_mosi.size(), txn);
    for (int i = 0; i < txn; i++) begin
      exp_b = exp_mosi.pop_front();
      if (i < slave_mosi.size())
        check_value("copi_o byte", slave_mosi[i], exp_b);
    end
    // Drain the RX FIFO head by head
    for (int i = 0; i < rxn; i++) begin
      check_value("rx_avail_o", rx_avail, 1'b1);
      check_value("rx_data_o", rx_data, slave_miso[i]);
      @(posedge clk);
      rx_dequeue <= 1'b1;
      @(posedge clk);
      rx_dequeue <= 1'b0;
      @(negedge clk);
    end
    check_value("rx_avail_o", rx_avail, 1'b0);
  endtask

  //////////////////////////////
  // Stimulus
  initial begin
    srst       = 1'b1;
    cmd        = '0;
    tx_data    = '0;
    tx_enqueue = 1'b0;
    rx_dequeue = 1'b0;
    cipo       = 1'b0;
    repeat (10) @(posedge clk);
    srst <= 1'b0;
    repeat (20) @(posedge clk);   // Parked bus before any go

    enqueue_bytes(3);             // Write only
    run_transfer(3, 0, 0);
    enqueue_bytes(1);             // Write, turnaround, read
    run_transfer(1, 2, 4);

    enqueue_bytes(spi_pkg::FIFO_DEPTH);
    @(negedge clk);
    check_value("tx_ready_o", tx_ready, 1'b0);   // Full
    run_transfer(15, 0, 0);
    run_transfer(1, 0, 0);
    check_value("tx_ready_o", tx_ready, 1'b1);

    enqueue_bytes(2);             // Read straight after write
    run_transfer(2, 0, 2);
    enqueue_bytes(1);             // Wait count ignored without RX
    run_transfer(1, 3, 0);

    repeat (4) @(negedge clk);
    print_counts();
    if (errors == 0 && chk_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/spi_pkg.sv
logic/spi_sync_fifo.sv
logic/spi_phase_gen.sv
logic/spi_cmd_latch.sv
logic/spi_bus_fsm.sv
logic/spi_rx_shifter.sv
logic/spi_master_top.sv
test/tb_clk_gen.sv
test/spi_master_chk.sv
test/tb_spi_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the SPI master testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_master -f tb.f -o Vtb_spi_master

./obj_dir/Vtb_spi_master +verilator+error+limit+1000 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
grep -q "sim passed" sim.log
